// File: common/axi_pkg.sv
`default_nettype none

package axi_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int LEN_WIDTH  = 8;
	localparam int SIZE_WIDTH = 3;
	localparam int STRB_WIDTH = 4;

	localparam int MID_WIDTH = 4; // id as seen by a master
	localparam int SID_WIDTH = 8; // id as seen by a slave

	typedef logic [MID_WIDTH-1:0] mid_t;
	typedef logic [SID_WIDTH-1:0] sid_t;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} burst_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	// shared by AR and AW
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len; // beats minus one
		logic [SIZE_WIDTH-1:0] size;
		burst_e                burst;
	} addr_req_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		resp_e                 resp;
		logic                  last;
	} r_beat_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
		logic                  last;
	} w_beat_t;

endpackage

`default_nettype wire

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA
	} read_state_e;

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_DATA,
		W_RESP
	} write_state_e;

	// upper part of the slave side id
	localparam int BRIDGE_ID_WIDTH = axi_pkg::SID_WIDTH - axi_pkg::MID_WIDTH;
	localparam logic [BRIDGE_ID_WIDTH-1:0] BRIDGE_ID = '0;

	// region field picks the slave and the top slave is the default one
	localparam int REGION_LSB   = 16;
	localparam int REGION_WIDTH = 2;

endpackage

`default_nettype wire

// File: hw/axi_bus.sv
`default_nettype none

module axi_bus #(
	parameter int MASTER_NUM = 5,
	parameter int SLAVE_NUM  = 3
) (
	input  logic                                   ACLK,
	input  logic                                   ARESETn,
	// master side
	input  axi_pkg::addr_req_t [MASTER_NUM-1:0]    m_ar,
	input  axi_pkg::mid_t      [MASTER_NUM-1:0]    m_ar_id,
	input  logic               [MASTER_NUM-1:0]    m_ar_valid,
	output logic               [MASTER_NUM-1:0]    m_ar_ready,
	output axi_pkg::r_beat_t   [MASTER_NUM-1:0]    m_r,
	output axi_pkg::mid_t      [MASTER_NUM-1:0]    m_r_id,
	output logic               [MASTER_NUM-1:0]    m_r_valid,
	input  logic               [MASTER_NUM-1:0]    m_r_ready,
	input  axi_pkg::addr_req_t [MASTER_NUM-1:0]    m_aw,
	input  axi_pkg::mid_t      [MASTER_NUM-1:0]    m_aw_id,
	input  logic               [MASTER_NUM-1:0]    m_aw_valid,
	output logic               [MASTER_NUM-1:0]    m_aw_ready,
	input  axi_pkg::w_beat_t   [MASTER_NUM-1:0]    m_w,
	input  logic               [MASTER_NUM-1:0]    m_w_valid,
	output logic               [MASTER_NUM-1:0]    m_w_ready,
	output axi_pkg::resp_e     [MASTER_NUM-1:0]    m_b_resp,
	output axi_pkg::mid_t      [MASTER_NUM-1:0]    m_b_id,
	output logic               [MASTER_NUM-1:0]    m_b_valid,
	input  logic               [MASTER_NUM-1:0]    m_b_ready,
	// slave side
	output axi_pkg::addr_req_t [SLAVE_NUM-1:0]     s_ar,
	output axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_ar_id,
	output logic               [SLAVE_NUM-1:0]     s_ar_valid,
	input  logic               [SLAVE_NUM-1:0]     s_ar_ready,
	input  axi_pkg::r_beat_t   [SLAVE_NUM-1:0]     s_r,
	input  axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_r_id,
	input  logic               [SLAVE_NUM-1:0]     s_r_valid,
	output logic               [SLAVE_NUM-1:0]     s_r_ready,
	output axi_pkg::addr_req_t [SLAVE_NUM-1:0]     s_aw,
	output axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_aw_id,
	output logic               [SLAVE_NUM-1:0]     s_aw_valid,
	input  logic               [SLAVE_NUM-1:0]     s_aw_ready,
	output axi_pkg::w_beat_t   [SLAVE_NUM-1:0]     s_w,
	output logic               [SLAVE_NUM-1:0]     s_w_valid,
	input  logic               [SLAVE_NUM-1:0]     s_w_ready,
	input  axi_pkg::resp_e     [SLAVE_NUM-1:0]     s_b_resp,
	input  axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_b_id,
	input  logic               [SLAVE_NUM-1:0]     s_b_valid,
	output logic               [SLAVE_NUM-1:0]     s_b_ready
);

	// read and write run independently
	read_channel #(
		.MASTER_NUM(MASTER_NUM),
		.SLAVE_NUM (SLAVE_NUM)
	) read_channel_inst (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.m_ar      (m_ar),
		.m_ar_id   (m_ar_id),
		.m_ar_valid(m_ar_valid),
		.m_ar_ready(m_ar_ready),
		.m_r       (m_r),
		.m_r_id    (m_r_id),
		.m_r_valid (m_r_valid),
		.m_r_ready (m_r_ready),
		.s_ar      (s_ar),
		.s_ar_id   (s_ar_id),
		.s_ar_valid(s_ar_valid),
		.s_ar_ready(s_ar_ready),
		.s_r       (s_r),
		.s_r_id    (s_r_id),
		.s_r_valid (s_r_valid),
		.s_r_ready (s_r_ready)
	);

	write_channel #(
		.MASTER_NUM(MASTER_NUM),
		.SLAVE_NUM (SLAVE_NUM)
	) write_channel_inst (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.m_aw      (m_aw),
		.m_aw_id   (m_aw_id),
		.m_aw_valid(m_aw_valid),
		.m_aw_ready(m_aw_ready),
		.m_w       (m_w),
		.m_w_valid (m_w_valid),
		.m_w_ready (m_w_ready),
		.m_b_resp  (m_b_resp),
		.m_b_id    (m_b_id),
		.m_b_valid (m_b_valid),
		.m_b_ready (m_b_ready),
		.s_aw      (s_aw),
		.s_aw_id   (s_aw_id),
		.s_aw_valid(s_aw_valid),
		.s_aw_ready(s_aw_ready),
		.s_w       (s_w),
		.s_w_valid (s_w_valid),
		.s_w_ready (s_w_ready),
		.s_b_resp  (s_b_resp),
		.s_b_id    (s_b_id),
		.s_b_valid (s_b_valid),
		.s_b_ready (s_b_ready)
	);

endmodule

`default_nettype wire

// File: hw/grant_select.sv
`default_nettype none

module grant_select #(
	parameter int MASTER_NUM = 5,
	parameter int SLAVE_NUM  = 3
) (
	input  logic [MASTER_NUM-1:0]                         request,
	input  logic [MASTER_NUM-1:0][axi_pkg::ADDR_WIDTH-1:0] addr,
	output logic [MASTER_NUM-1:0]                         master_onehot,
	output logic [SLAVE_NUM-1:0]                          slave_onehot
);
	import axi_pkg::*;
	import bus_pkg::*;

	logic [ADDR_WIDTH-1:0]   win_addr;
	logic [REGION_WIDTH-1:0] region;

	// isolate lowest set bit
	assign master_onehot = request & (~request + 1'b1);

	always_comb begin
		win_addr = '0;
		for (int i = 0; i < MASTER_NUM; i++) begin
			if (master_onehot[i]) begin
				win_addr = addr[i];
			end
		end
	end

	assign region = win_addr[REGION_LSB +: REGION_WIDTH];

	always_comb begin
		slave_onehot = '0;
		if (|request) begin
			if (int'(region) < SLAVE_NUM - 1) begin
				slave_onehot[region] = 1'b1;
			end else begin
				slave_onehot[SLAVE_NUM-1] = 1'b1; // default slave
			end
		end
	end

endmodule

`default_nettype wire

// File: list.f
common/axi_pkg.sv
common/bus_pkg.sv
hw/grant_select.sv
read_channel/read_channel.sv
write_channel/write_channel.sv
hw/axi_bus.sv
testbench/tb_slave_model.sv
testbench/tb_axi_bus.sv

// File: read_channel/read_channel.sv
`default_nettype none

module read_channel #(
	parameter int MASTER_NUM = 5,
	parameter int SLAVE_NUM  = 3
) (
	input  logic                                   ACLK,
	input  logic                                   ARESETn,
	input  axi_pkg::addr_req_t [MASTER_NUM-1:0]    m_ar,
	input  axi_pkg::mid_t      [MASTER_NUM-1:0]    m_ar_id,
	input  logic               [MASTER_NUM-1:0]    m_ar_valid,
	output logic               [MASTER_NUM-1:0]    m_ar_ready,
	output axi_pkg::r_beat_t   [MASTER_NUM-1:0]    m_r,
	output axi_pkg::mid_t      [MASTER_NUM-1:0]    m_r_id,
	output logic               [MASTER_NUM-1:0]    m_r_valid,
	input  logic               [MASTER_NUM-1:0]    m_r_ready,
	output axi_pkg::addr_req_t [SLAVE_NUM-1:0]     s_ar,
	output axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_ar_id,
	output logic               [SLAVE_NUM-1:0]     s_ar_valid,
	input  logic               [SLAVE_NUM-1:0]     s_ar_ready,
	input  axi_pkg::r_beat_t   [SLAVE_NUM-1:0]     s_r,
	input  axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_r_id,
	input  logic               [SLAVE_NUM-1:0]     s_r_valid,
	output logic               [SLAVE_NUM-1:0]     s_r_ready
);
	import axi_pkg::*;
	import bus_pkg::*;

	read_state_e state, next_state;

	logic [MASTER_NUM-1:0][ADDR_WIDTH-1:0] ar_addr;
	logic [MASTER_NUM-1:0] grant_mst;
	logic [SLAVE_NUM-1:0]  grant_slv;
	logic [MASTER_NUM-1:0] mst_sel; // held for the whole burst
	logic [SLAVE_NUM-1:0]  slv_sel;

	addr_req_t ar_sel;
	mid_t      ar_id_sel;
	logic      ar_valid_sel;
	logic      ar_ready_sel;
	r_beat_t   r_sel;
	sid_t      r_id_sel;
	logic      r_valid_sel;
	logic      r_ready_sel;

	always_comb begin
		for (int i = 0; i < MASTER_NUM; i++) begin
			ar_addr[i] = m_ar[i].addr;
		end
	end

	grant_select #(
		.MASTER_NUM(MASTER_NUM),
		.SLAVE_NUM (SLAVE_NUM)
	) ar_grant_inst (
		.request      (m_ar_valid),
		.addr         (ar_addr),
		.master_onehot(grant_mst),
		.slave_onehot (grant_slv)
	);

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state   <= R_IDLE;
			mst_sel <= '0;
			slv_sel <= '0;
		end else begin
			state <= next_state;
			if (state == R_IDLE && |grant_mst) begin
				mst_sel <= grant_mst;
				slv_sel <= grant_slv;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			R_IDLE: if (|grant_mst) next_state = R_ADDR;
			R_ADDR: if (ar_valid_sel && ar_ready_sel) next_state = R_DATA;
			R_DATA: if (r_valid_sel && r_ready_sel && r_sel.last) next_state = R_IDLE;
			default: next_state = R_IDLE;
		endcase
	end

	// pick the held master and slave
	always_comb begin
		ar_sel       = '0;
		ar_id_sel    = '0;
		ar_valid_sel = 1'b0;
		r_ready_sel  = 1'b0;
		ar_ready_sel = 1'b0;
		r_sel        = '0;
		r_id_sel     = '0;
		r_valid_sel  = 1'b0;
		for (int i = 0; i < MASTER_NUM; i++) begin
			if (mst_sel[i]) begin
				ar_sel       = m_ar[i];
				ar_id_sel    = m_ar_id[i];
				ar_valid_sel = m_ar_valid[i];
				r_ready_sel  = m_r_ready[i];
			end
		end
		for (int j = 0; j < SLAVE_NUM; j++) begin
			if (slv_sel[j]) begin
				ar_ready_sel = s_ar_ready[j];
				r_sel        = s_r[j];
				r_id_sel     = s_r_id[j];
				r_valid_sel  = s_r_valid[j];
			end
		end
	end

	always_comb begin
		m_ar_ready = '0;
		m_r        = '0;
		m_r_id     = '0;
		m_r_valid  = '0;
		for (int i = 0; i < MASTER_NUM; i++) begin
			if (mst_sel[i]) begin
				m_ar_ready[i] = (state == R_ADDR) && ar_ready_sel;
				if (state == R_DATA) begin
					m_r[i]       = r_sel;
					m_r_id[i]    = r_id_sel[MID_WIDTH-1:0]; // drop bridge id
					m_r_valid[i] = r_valid_sel;
				end
			end
		end
	end

	always_comb begin
		s_ar       = '0;
		s_ar_id    = '0;
		s_ar_valid = '0;
		s_r_ready  = '0;
		for (int j = 0; j < SLAVE_NUM; j++) begin
			if (slv_sel[j]) begin
				if (state == R_ADDR) begin
					s_ar[j]       = ar_sel;
					s_ar_id[j]    = {BRIDGE_ID, ar_id_sel};
					s_ar_valid[j] = ar_valid_sel;
				end
				s_r_ready[j] = (state == R_DATA) && r_ready_sel;
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_axi_bus -f list.f -o sim_axi_bus > build.log 2>&1 &&
	./obj_dir/sim_axi_bus > sim.log 2>&1
grep -q "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/tb_axi_bus.sv
`default_nettype none

module tb_axi_bus;
	import axi_pkg::*;

	localparam int M = 5;
	localparam int S = 3;
	localparam int TIMEOUT = 300;

	logic ACLK = 1'b0;
	logic ARESETn;

	addr_req_t [M-1:0] m_ar, m_aw;
	mid_t      [M-1:0] m_ar_id, m_r_id, m_aw_id, m_b_id;
	logic      [M-1:0] m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
	logic      [M-1:0] m_aw_valid, m_aw_ready, m_w_valid, m_w_ready;
	logic      [M-1:0] m_b_valid, m_b_ready;
	r_beat_t   [M-1:0] m_r;
	w_beat_t   [M-1:0] m_w;
	resp_e     [M-1:0] m_b_resp;

	addr_req_t [S-1:0] s_ar, s_aw;
	sid_t      [S-1:0] s_ar_id, s_r_id, s_aw_id, s_b_id;
	logic      [S-1:0] s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
	logic      [S-1:0] s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
	logic      [S-1:0] s_b_valid, s_b_ready;
	r_beat_t   [S-1:0] s_r;
	w_beat_t   [S-1:0] s_w;
	resp_e     [S-1:0] s_b_resp;

	logic [31:0] rnd = 32'h8022_82af;
	logic        idle_check = 1'b0;
	logic        m1_done = 1'b0;
	int          exp_slave = 0;
	mid_t        cur_aw_id = '0;
	addr_req_t   cur_aw = '0;

	always #50 ACLK = ~ACLK;

	axi_bus axi_bus_inst (.*);

	for (genvar j = 0; j < S; j++) begin : slave_gen
		tb_slave_model #(.INDEX(j)) slave_inst (
			.ACLK(ACLK), .ARESETn(ARESETn),
			.ar(s_ar[j]), .ar_id(s_ar_id[j]), .ar_valid(s_ar_valid[j]), .ar_ready(s_ar_ready[j]),
			.r(s_r[j]), .r_id(s_r_id[j]), .r_valid(s_r_valid[j]), .r_ready(s_r_ready[j]),
			.aw(s_aw[j]), .aw_id(s_aw_id[j]), .aw_valid(s_aw_valid[j]), .aw_ready(s_aw_ready[j]),
			.w(s_w[j]), .w_valid(s_w_valid[j]), .w_ready(s_w_ready[j]),
			.b_resp(s_b_resp[j]), .b_id(s_b_id[j]), .b_valid(s_b_valid[j]), .b_ready(s_b_ready[j])
		);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic aw_request_ok();
		logic ok;
		ok = 1'b1;
		for (int j = 0; j < S; j++) begin
			if (s_aw_valid[j] && s_aw_id[j] !== {4'h0, cur_aw_id}) ok = 1'b0;
			if (s_aw_valid[j] && s_aw[j] !== cur_aw) ok = 1'b0;
		end
		return ok;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// untouched words still hold the slave model fill pattern
	task automatic check_fill(input string name, input int slave, input logic [31:0] a,
		input logic [31:0] data[$]);
		logic [7:0] idx;
		for (int b = 0; b < data.size(); b++) begin
			idx = a[9:2] + 8'(b);
			check_value(name, {8'(slave), idx, ~idx, idx}, data[b]);
		end
	endtask

	a_idle: assert property (@(posedge ACLK) disable iff (!ARESETn) idle_check |->
		(m_ar_ready == 0 && m_r_valid == 0 && m_aw_ready == 0 && m_w_ready == 0 &&
		m_b_valid == 0 && s_ar_valid == 0 && s_aw_valid == 0 && s_w_valid == 0))
		else begin
			$display("bus outputs became active while all masters were idle");
			$display("test failed");
			$fatal(1);
		end

	a_decode: assert property (@(posedge ACLK) disable iff (!ARESETn)
		|s_ar_valid |-> s_ar_valid == 3'(1 << exp_slave))
		else begin
			$display("FAILED decode expected %b actual %b", 3'(1 << exp_slave), s_ar_valid);
			$display("test failed");
			$fatal(1);
		end

	a_aw_req: assert property (@(posedge ACLK) disable iff (!ARESETn)
		|s_aw_valid |-> aw_request_ok())
		else begin
			$display("FAILED s_aw expected %h id %h actual %h id %h",
				cur_aw, {4'h0, cur_aw_id}, s_aw, s_aw_id);
			$display("test failed");
			$fatal(1);
		end

	a_priority: assert property (@(posedge ACLK) disable iff (!ARESETn)
		m_ar_valid[1] |-> !m_ar_ready[3])
		else begin
			$display("master 3 got the read address while master 1 was waiting");
			$display("test failed");
			$fatal(1);
		end

	a_order: assert property (@(posedge ACLK) disable iff (!ARESETn)
		m_ar_valid[3] && m_ar_ready[3] |-> m1_done)
		else begin
			$display("master 3 was served before master 1 finished its burst");
			$display("test failed");
			$fatal(1);
		end

	a_r_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
		|(m_r_valid & ~m_r_ready) |=> $stable(m_r) && $stable(m_r_valid))
		else begin
			$display("read beat changed while it was waiting for ready");
			$display("test failed");
			$fatal(1);
		end

	a_b_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
		|(m_b_valid & ~m_b_ready) |=>
		$stable(m_b_id) && $stable(m_b_resp) && $stable(m_b_valid))
		else begin
			$display("write response changed while it was waiting for ready");
			$display("test failed");
			$fatal(1);
		end

	task automatic write_burst(input int m, input logic [31:0] a, input mid_t id,
		input logic [31:0] data[$]);
		int n;
		cur_aw_id = id;
		cur_aw = '{addr: a, len: 8'(data.size() - 1), size: 3'd2, burst: INCR};
		m_aw[m] <= cur_aw;
		m_aw_id[m] <= id;
		m_aw_valid[m] <= 1'b1;
		for (n = 0; n < TIMEOUT; n++) begin
			@(posedge ACLK);
			if (m_aw_valid[m] && m_aw_ready[m]) break;
		end
		if (n == TIMEOUT) report_failure("timeout waiting for write address ready");
		m_aw_valid[m] <= 1'b0;
		for (int b = 0; b < data.size(); b++) begin
			m_w[m] <= '{data: data[b], strb: 4'hf, last: (b == data.size() - 1)};
			m_w_valid[m] <= 1'b1;
			for (n = 0; n < TIMEOUT; n++) begin
				@(posedge ACLK);
				if (m_w_valid[m] && m_w_ready[m]) break;
			end
			if (n == TIMEOUT) report_failure("timeout waiting for write data ready");
		end
		m_w_valid[m] <= 1'b0;
		m_b_ready[m] <= 1'b0;
		for (n = 0; n < TIMEOUT; n++) begin
			@(posedge ACLK);
			if (m_b_valid[m] && m_b_ready[m]) break;
			rnd = xorshift(rnd);
			m_b_ready[m] <= rnd[0]; // random stall
		end
		if (n == TIMEOUT) report_failure("timeout waiting for write response");
		check_value("b_resp", 32'(OKAY), 32'(m_b_resp[m]));
		check_value("b_id", 32'(id), 32'(m_b_id[m]));
		m_b_ready[m] <= 1'b0;
	endtask

	task automatic read_burst(input int m, input logic [31:0] a, input mid_t id,
		input int beats, output logic [31:0] data[$]);
		int n;
		data = {};
		m_ar[m] <= '{addr: a, len: 8'(beats - 1), size: 3'd2, burst: INCR};
		m_ar_id[m] <= id;
		m_ar_valid[m] <= 1'b1;
		for (n = 0; n < TIMEOUT; n++) begin
			@(posedge ACLK);
			if (m_ar_valid[m] && m_ar_ready[m]) break;
		end
		if (n == TIMEOUT) report_failure("timeout waiting for read address ready");
		check_value("s_ar_id", 32'({4'h0, id}), 32'(s_ar_id[exp_slave]));
		check_value("s_ar_addr", a, s_ar[exp_slave].addr);
		check_value("s_ar_len", 32'(beats - 1), 32'(s_ar[exp_slave].len));
		check_value("s_ar_size", 32'd2, 32'(s_ar[exp_slave].size));
		check_value("s_ar_burst", 32'(INCR), 32'(s_ar[exp_slave].burst));
		m_ar_valid[m] <= 1'b0;
		for (int b = 0; b < beats; b++) begin
			for (n = 0; n < TIMEOUT; n++) begin
				rnd = xorshift(rnd);
				m_r_ready[m] <= rnd[1];
				@(posedge ACLK);
				if (m_r_valid[m] && m_r_ready[m]) break;
			end
			if (n == TIMEOUT) report_failure("timeout waiting for read data");
			data.push_back(m_r[m].data);
			check_value("r_last", 32'(b == beats - 1), 32'(m_r[m].last));
			check_value("r_id", 32'(id), 32'(m_r_id[m]));
			check_value("r_resp", 32'(OKAY), 32'(m_r[m].resp));
		end
		m_r_ready[m] <= 1'b0;
	endtask

	initial begin
		logic [31:0] wdata[$];
		logic [31:0] rdata[$];
		logic [31:0] q3[$];
		logic [31:0] q4[$];
		ARESETn = 1'b0;
		m_ar = '0;
		m_ar_id = '0;
		m_ar_valid = '0;
		m_r_ready = '0;
		m_aw = '0;
		m_aw_id = '0;
		m_aw_valid = '0;
		m_w = '0;
		m_w_valid = '0;
		m_b_ready = '0;
		repeat (3) @(posedge ACLK);
		ARESETn <= 1'b1;
		idle_check = 1'b1;
		repeat (7) @(posedge ACLK);
		idle_check = 1'b0;

		// write then read back on slave 1
		for (int i = 0; i < 4; i++) begin
			rnd = xorshift(rnd);
			wdata.push_back(rnd);
		end
		write_burst(0, 32'h0001_0040, 4'h5, wdata);
		exp_slave = 1;
		read_burst(0, 32'h0001_0040, 4'h5, 4, rdata);
		for (int i = 0; i < 4; i++) check_value("read back", wdata[i], rdata[i]);

		// region 3 lands on the default slave
		exp_slave = 0;
		read_burst(0, 32'h0000_0100, 4'h1, 1, rdata);
		check_fill("decode slave 0", 0, 32'h0000_0100, rdata);
		exp_slave = 1;
		read_burst(0, 32'h0001_0100, 4'h1, 1, rdata);
		check_fill("decode slave 1", 1, 32'h0001_0100, rdata);
		exp_slave = 2;
		read_burst(0, 32'h0003_0100, 4'h1, 1, rdata);
		check_fill("decode slave 2", 2, 32'h0003_0100, rdata);

		exp_slave = 0;
		fork
			begin
				read_burst(1, 32'h0000_0200, 4'h1, 4, rdata);
				m1_done = 1'b1;
			end
			read_burst(3, 32'h0000_0300, 4'h3, 2, q3);
		join
		check_fill("priority master 1", 0, 32'h0000_0200, rdata);
		check_fill("priority master 3", 0, 32'h0000_0300, q3);

		wdata = {};
		for (int i = 0; i < 4; i++) begin
			rnd = xorshift(rnd);
			wdata.push_back(rnd);
		end
		exp_slave = 2;
		fork
			write_burst(2, 32'h0000_0080, 4'h2, wdata);
			read_burst(4, 32'h0002_0000, 4'h4, 6, q4);
		join
		check_fill("concurrent read", 2, 32'h0002_0000, q4);
		exp_slave = 0;
		read_burst(2, 32'h0000_0080, 4'h2, 4, rdata);
		for (int i = 0; i < 4; i++) check_value("concurrent write", wdata[i], rdata[i]);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_slave_model.sv
`default_nettype none

module tb_slave_model #(
	parameter int INDEX = 0
) (
	input  logic               ACLK,
	input  logic               ARESETn,
	input  axi_pkg::addr_req_t ar,
	input  axi_pkg::sid_t      ar_id,
	input  logic               ar_valid,
	output logic               ar_ready,
	output axi_pkg::r_beat_t   r,
	output axi_pkg::sid_t      r_id,
	output logic               r_valid,
	input  logic               r_ready,
	input  axi_pkg::addr_req_t aw,
	input  axi_pkg::sid_t      aw_id,
	input  logic               aw_valid,
	output logic               aw_ready,
	input  axi_pkg::w_beat_t   w,
	input  logic               w_valid,
	output logic               w_ready,
	output axi_pkg::resp_e     b_resp,
	output axi_pkg::sid_t      b_id,
	output logic               b_valid,
	input  logic               b_ready
);
	import axi_pkg::*;

	logic [31:0] mem [256];
	logic [31:0] rnd = 32'h8022_82af ^ INDEX;
	logic        rd_busy, wr_busy, b_pend;
	logic [7:0]  rd_ptr, rd_left, wr_ptr;
	sid_t        rd_id, wr_id;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'(INDEX), 8'(i), ~8'(i), 8'(i)}; // per-address pattern
		end
	end

	always @(posedge ACLK) begin
		rnd = xorshift(rnd);
		if (!ARESETn) begin
			ar_ready <= 1'b0;
			r        <= '0;
			r_id     <= '0;
			r_valid  <= 1'b0;
			aw_ready <= 1'b0;
			w_ready  <= 1'b0;
			b_resp   <= OKAY;
			b_id     <= '0;
			b_valid  <= 1'b0;
			rd_busy  <= 1'b0;
			wr_busy  <= 1'b0;
			b_pend   <= 1'b0;
		end else begin
			if (ar_valid && ar_ready) begin
				rd_busy  <= 1'b1;
				rd_ptr   <= ar.addr[9:2];
				rd_left  <= ar.len;
				rd_id    <= ar_id;
				ar_ready <= 1'b0;
			end else begin
				ar_ready <= !rd_busy && rnd[0];
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				rd_ptr  <= rd_ptr + 1'b1;
				rd_left <= rd_left - 1'b1;
				if (r.last) rd_busy <= 1'b0;
			end else if (rd_busy && !r_valid && rnd[1]) begin
				r_valid <= 1'b1;
				r       <= '{data: mem[rd_ptr], resp: OKAY, last: (rd_left == 8'd0)};
				r_id    <= rd_id; // echo id
			end
			if (aw_valid && aw_ready) begin
				wr_busy  <= 1'b1;
				wr_ptr   <= aw.addr[9:2];
				wr_id    <= aw_id;
				aw_ready <= 1'b0;
			end else begin
				aw_ready <= !wr_busy && rnd[2];
			end
			if (w_valid && w_ready) begin
				for (int k = 0; k < 4; k++) begin
					if (w.strb[k]) mem[wr_ptr][8*k +: 8] <= w.data[8*k +: 8];
				end
				wr_ptr  <= wr_ptr + 1'b1;
				w_ready <= 1'b0;
				if (w.last) b_pend <= 1'b1;
			end else begin
				w_ready <= wr_busy && !b_pend && rnd[3];
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				b_pend  <= 1'b0;
				wr_busy <= 1'b0;
			end else if (b_pend && !b_valid && rnd[4]) begin
				b_valid <= 1'b1;
				b_resp  <= OKAY;
				b_id    <= wr_id;
			end
		end
	end

endmodule

`default_nettype wire

// File: write_channel/write_channel.sv
`default_nettype none

module write_channel #(
	parameter int MASTER_NUM = 5,
	parameter int SLAVE_NUM  = 3
) (
	input  logic                                   ACLK,
	input  logic                                   ARESETn,
	input  axi_pkg::addr_req_t [MASTER_NUM-1:0]    m_aw,
	input  axi_pkg::mid_t      [MASTER_NUM-1:0]    m_aw_id,
	input  logic               [MASTER_NUM-1:0]    m_aw_valid,
	output logic               [MASTER_NUM-1:0]    m_aw_ready,
	input  axi_pkg::w_beat_t   [MASTER_NUM-1:0]    m_w,
	input  logic               [MASTER_NUM-1:0]    m_w_valid,
	output logic               [MASTER_NUM-1:0]    m_w_ready,
	output axi_pkg::resp_e     [MASTER_NUM-1:0]    m_b_resp,
	output axi_pkg::mid_t      [MASTER_NUM-1:0]    m_b_id,
	output logic               [MASTER_NUM-1:0]    m_b_valid,
	input  logic               [MASTER_NUM-1:0]    m_b_ready,
	output axi_pkg::addr_req_t [SLAVE_NUM-1:0]     s_aw,
	output axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_aw_id,
	output logic               [SLAVE_NUM-1:0]     s_aw_valid,
	input  logic               [SLAVE_NUM-1:0]     s_aw_ready,
	output axi_pkg::w_beat_t   [SLAVE_NUM-1:0]     s_w,
	output logic               [SLAVE_NUM-1:0]     s_w_valid,
	input  logic               [SLAVE_NUM-1:0]     s_w_ready,
	input  axi_pkg::resp_e     [SLAVE_NUM-1:0]     s_b_resp,
	input  axi_pkg::sid_t      [SLAVE_NUM-1:0]     s_b_id,
	input  logic               [SLAVE_NUM-1:0]     s_b_valid,
	output logic               [SLAVE_NUM-1:0]     s_b_ready
);
	import axi_pkg::*;
	import bus_pkg::*;

	write_state_e state, next_state;

	logic [MASTER_NUM-1:0][ADDR_WIDTH-1:0] aw_addr;
	logic [MASTER_NUM-1:0] grant_mst;
	logic [SLAVE_NUM-1:0]  grant_slv;
	logic [MASTER_NUM-1:0] mst_sel;
	logic [SLAVE_NUM-1:0]  slv_sel;

	addr_req_t aw_sel;
	mid_t      aw_id_sel;
	logic      aw_valid_sel;
	logic      aw_ready_sel;
	w_beat_t   w_sel;
	logic      w_valid_sel;
	logic      w_ready_sel;
	resp_e     b_resp_sel;
	sid_t      b_id_sel;
	logic      b_valid_sel;
	logic      b_ready_sel;

	always_comb begin
		for (int i = 0; i < MASTER_NUM; i++) begin
			aw_addr[i] = m_aw[i].addr;
		end
	end

	grant_select #(
		.MASTER_NUM(MASTER_NUM),
		.SLAVE_NUM (SLAVE_NUM)
	) aw_grant_inst (
		.request      (m_aw_valid),
		.addr         (aw_addr),
		.master_onehot(grant_mst),
		.slave_onehot (grant_slv)
	);

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state   <= W_IDLE;
			mst_sel <= '0;
			slv_sel <= '0;
		end else begin
			state <= next_state;
			if (state == W_IDLE && |grant_mst) begin
				mst_sel <= grant_mst;
				slv_sel <= grant_slv;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			W_IDLE: if (|grant_mst) next_state = W_ADDR;
			W_ADDR: if (aw_valid_sel && aw_ready_sel) next_state = W_DATA;
			W_DATA: if (w_valid_sel && w_ready_sel && w_sel.last) next_state = W_RESP;
			W_RESP: if (b_valid_sel && b_ready_sel) next_state = W_IDLE;
			default: next_state = W_IDLE;
		endcase
	end

	always_comb begin
		aw_sel       = '0;
		aw_id_sel    = '0;
		aw_valid_sel = 1'b0;
		w_sel        = '0;
		w_valid_sel  = 1'b0;
		b_ready_sel  = 1'b0;
		aw_ready_sel = 1'b0;
		w_ready_sel  = 1'b0;
		b_resp_sel   = OKAY;
		b_id_sel     = '0;
		b_valid_sel  = 1'b0;
		for (int i = 0; i < MASTER_NUM; i++) begin
			if (mst_sel[i]) begin
				aw_sel       = m_aw[i];
				aw_id_sel    = m_aw_id[i];
				aw_valid_sel = m_aw_valid[i];
				w_sel        = m_w[i];
				w_valid_sel  = m_w_valid[i];
				b_ready_sel  = m_b_ready[i];
			end
		end
		for (int j = 0; j < SLAVE_NUM; j++) begin
			if (slv_sel[j]) begin
				aw_ready_sel = s_aw_ready[j];
				w_ready_sel  = s_w_ready[j];
				b_resp_sel   = s_b_resp[j];
				b_id_sel     = s_b_id[j];
				b_valid_sel  = s_b_valid[j];
			end
		end
	end

	always_comb begin
		m_aw_ready = '0;
		m_w_ready  = '0;
		m_b_id     = '0;
		m_b_valid  = '0;
		for (int i = 0; i < MASTER_NUM; i++) begin
			m_b_resp[i] = OKAY;
			if (mst_sel[i]) begin
				m_aw_ready[i] = (state == W_ADDR) && aw_ready_sel;
				m_w_ready[i]  = (state == W_DATA) && w_ready_sel;
				if (state == W_RESP) begin
					m_b_resp[i]  = b_resp_sel;
					m_b_id[i]    = b_id_sel[MID_WIDTH-1:0]; // drop bridge id
					m_b_valid[i] = b_valid_sel;
				end
			end
		end
	end

	always_comb begin
		s_aw       = '0;
		s_aw_id    = '0;
		s_aw_valid = '0;
		s_w        = '0;
		s_w_valid  = '0;
		s_b_ready  = '0;
		for (int j = 0; j < SLAVE_NUM; j++) begin
			if (slv_sel[j]) begin
				if (state == W_ADDR) begin
					s_aw[j]       = aw_sel;
					s_aw_id[j]    = {BRIDGE_ID, aw_id_sel};
					s_aw_valid[j] = aw_valid_sel;
				end
				if (state == W_DATA) begin
					s_w[j]       = w_sel;
					s_w_valid[j] = w_valid_sel;
				end
				s_b_ready[j] = (state == W_RESP) && b_ready_sel;
			end
		end
	end

endmodule

`default_nettype wire
